// ==== sources.f ====
+incdir+design
design/dxt_pkg.sv
design/dxt_wb_decode.sv
design/dxt_table_port.sv
design/dxt_table_ram.sv
design/dxt_wb_result.sv
design/dxt_top.sv
verif/dxt_checker.sv
verif/dxt_tb.sv

// ==== verif/dxt_golden.txt ====
# columns: op addr data expected, all hex; addr is a byte address or a controller index
# op: 0 sw write, 1 sw read, 2 DAT read, 3 DCT write, 4 DCT read, 5 sw read start, 6 sw read end
# DAT entry written in halves, controller sees the low word at the lower address
0 018 a5a50001 0
0 01c 5a5a0002 0
2 003 0 5a5a0002a5a50001
1 018 0 a5a50001
1 01c 0 5a5a0002
# One half rewritten, the other half holds
0 028 11112222 0
0 02c 33334444 0
0 028 55556666 0
1 02c 0 33334444
1 028 0 55556666
2 005 0 3333444455556666
2 003 0 5a5a0002a5a50001
# Controller DCT entry, read by software in quarters
3 002 dddd0003cccc0002bbbb0001aaaa0000 0
4 002 0 dddd0003cccc0002bbbb0001aaaa0000
1 820 0 aaaa0000
1 824 0 bbbb0001
1 828 0 cccc0002
1 82c 0 dddd0003
# Software DCT writes are acknowledged and dropped
0 824 ffffffff 0
0 870 12345678 0
4 002 0 dddd0003cccc0002bbbb0001aaaa0000
4 007 0 0
1 824 0 bbbb0001
# Hole between the windows reads zero
1 400 0 0
1 7fc 0 0
0 500 deadbeef 0
1 500 0 0
# Last DAT entry
0 3fc cafe0127 0
1 3fc 0 cafe0127
2 07f 0 cafe012700000000
# Software read behind a burst of controller DAT reads
0 048 90900009 0
0 04c 09090909 0
5 04c 0 0
2 003 0 5a5a0002a5a50001
2 005 0 3333444455556666
2 009 0 0909090990900009
2 07f 0 cafe012700000000
2 003 0 5a5a0002a5a50001
6 04c 0 09090909
# Software read behind controller DCT reads
5 828 0 0
4 002 0 dddd0003cccc0002bbbb0001aaaa0000
4 007 0 0
4 002 0 dddd0003cccc0002bbbb0001aaaa0000
6 828 0 cccc0002
1 048 0 90900009

// ==== verif/dxt_tb.sv ====
// ##########################################################################
// DXT testbench, replays golden table operations and checks the responses
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "dxt_config.svh"

module dxt_tb;
  import dxt_pkg::*;

  localparam int unsigned AckTimeout = 50;

  logic                  clk;
  logic                  rst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`DXT_ADR_W-1:0] wb_adr;
  logic [`DXT_WB_DW-1:0] wb_wdat;
  logic [`DXT_WB_DW-1:0] wb_rdat;
  logic                  wb_ack;
  logic                  dat_rd;
  dat_idx_t              dat_idx;
  dat_entry_t            dat_rdata;
  logic                  dct_wr;
  dct_idx_t              dct_widx;
  dct_entry_t            dct_wdata;
  logic                  dct_rd;
  dct_idx_t              dct_ridx;
  dct_entry_t            dct_rdata;

  // Current golden line and run state
  int                    fd;
  int                    n_fields;
  string                 line;
  logic [3:0]            op;
  logic [`DXT_ADR_W-1:0] op_adr;
  logic [127:0]          op_data;
  logic [127:0]          op_exp;
  logic [31:0]           rng;
  logic                  pending;
  logic                  timed_out;
  logic                  test_ok;
  int                    tests;
  int                    failed;
  int                    errors;
  int                    assert_fails;

  dxt_top dxt_top_i (
    .clk_i(clk), .rst_ni(rst_n), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
    .dat_rd_i(dat_rd), .dat_idx_i(dat_idx), .dat_rdata_o(dat_rdata),
    .dct_wr_i(dct_wr), .dct_widx_i(dct_widx), .dct_wdata_i(dct_wdata),
    .dct_rd_i(dct_rd), .dct_ridx_i(dct_ridx), .dct_rdata_o(dct_rdata)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] got);
    errors++;
    test_ok = 1'b0;
    $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, got);
  endtask

  task automatic start_access(input logic we, input logic [`DXT_ADR_W-1:0] a,
                              input logic [31:0] wdat);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = a;
    wb_wdat = wdat;
  endtask

  // Strobe stays up through the ack edge, then stays low for one cycle
  task automatic finish_access(input logic [31:0] exp);
    int          cycles;
    logic        seen;
    logic [31:0] rdat;
    cycles = 0;
    seen   = 1'b0;
    rdat   = '0;
    while (!seen && cycles < AckTimeout) begin
      @(negedge clk);
      cycles++;
      seen = wb_ack;
      rdat = wb_rdat;
    end
    if (!seen) begin
      $display("Timeout: no wb_ack_o within %0d cycles for address %h", AckTimeout, wb_adr);
      errors++;
      test_ok   = 1'b0;
      timed_out = 1'b1;
    end else begin
      if (rdat !== exp) begin
        report_mismatch("wb_dat_o", 128'(exp), 128'(rdat));
      end
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic read_dat(input dat_idx_t idx, input dat_entry_t exp);
    dat_rd  = 1'b1;
    dat_idx = idx;
    @(negedge clk);
    dat_rd = 1'b0;
    if (dat_rdata !== exp) begin
      report_mismatch("dat_rdata_o", 128'(exp), 128'(dat_rdata));
    end
    // A held software read waits out the controller burst
    if (pending && wb_ack) begin
      report_mismatch("wb_ack_o", 128'(1'b0), 128'(wb_ack));
    end
  endtask

  task automatic write_dct(input dct_idx_t idx, input dct_entry_t wdata);
    dct_wr    = 1'b1;
    dct_widx  = idx;
    dct_wdata = wdata;
    @(negedge clk);
    dct_wr = 1'b0;
  endtask

  task automatic read_dct(input dct_idx_t idx, input dct_entry_t exp);
    dct_rd   = 1'b1;
    dct_ridx = idx;
    @(negedge clk);
    dct_rd = 1'b0;
    if (dct_rdata !== exp) begin
      report_mismatch("dct_rdata_o", exp, dct_rdata);
    end
    if (pending && wb_ack) begin
      report_mismatch("wb_ack_o", 128'(1'b0), 128'(wb_ack));
    end
  endtask

  task automatic run_op();
    test_ok = 1'b1;
    // No idle gap between a started read and its overlapping controller burst
    if (!pending) begin
      rng = next_random(rng);
      repeat (rng[1:0]) @(negedge clk);
    end
    case (op)
      4'h0, 4'h1: begin
        start_access(op == 4'h0, op_adr, op_data[31:0]);
        finish_access(op_exp[31:0]);
      end
      4'h2: read_dat(dat_idx_t'(op_adr), op_exp[63:0]);
      4'h3: write_dct(dct_idx_t'(op_adr), op_data);
      4'h4: read_dct(dct_idx_t'(op_adr), op_exp);
      4'h5: begin
        start_access(1'b0, op_adr, '0);
        pending = 1'b1;
      end
      4'h6: begin
        if (pending) begin
          finish_access(op_exp[31:0]);
          pending = 1'b0;
        end else begin
          $display("Error: end of a software read that was never started");
          errors++;
          test_ok = 1'b0;
        end
      end
      default: begin
        $display("Error: unknown operation code %h in the golden file", op);
        errors++;
        test_ok = 1'b0;
      end
    endcase
    tests++;
    if (!test_ok) begin
      failed++;
    end
    $display("test %0d: op %0h at %h %s", tests, op, op_adr, test_ok ? "ok" : "error");
  endtask

  initial begin
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_wdat   = '0;
    dat_rd    = 1'b0;
    dat_idx   = '0;
    dct_wr    = 1'b0;
    dct_widx  = '0;
    dct_wdata = '0;
    dct_rd    = 1'b0;
    dct_ridx  = '0;
    rst_n     = 1'b0;
    rng       = 32'h97961562;
    pending   = 1'b0;
    timed_out = 1'b0;
    tests     = 0;
    failed    = 0;
    errors    = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    fd = $fopen("verif/dxt_golden.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open verif/dxt_golden.txt");
      errors++;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        n_fields = 0;
        if ($fgets(line, fd) > 0 && line.len() > 0 && line[0] != "#") begin
          n_fields = $sscanf(line, "%h %h %h %h", op, op_adr, op_data, op_exp);
        end
        if (n_fields == 4) begin
          run_op();
        end
      end
      $fclose(fd);
    end
    if (pending && !timed_out) begin
      $display("Error: golden file ended with a software read still open");
      errors++;
    end
    assert_fails = dxt_top_i.dxt_checker_i.fail_count;
    $display("tests run: %0d, tests failed: %0d, errors: %0d, assertion failures: %0d",
             tests, failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0 && tests > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/dxt_checker.sv ====
// ##########################################################################
// DXT checker, assertions on the Wishbone handshake and controller ports
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module dxt_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              wb_cyc_i,
  input logic              wb_stb_i,
  input logic              wb_ack_i,
  input logic              dat_grant_i,
  input logic              dct_grant_i,
  input logic              dat_rd_i,
  input dxt_pkg::dat_idx_t dat_idx_i,
  input logic              dct_wr_i,
  input dxt_pkg::dct_idx_t dct_widx_i,
  input logic              dct_rd_i,
  input dxt_pkg::dct_idx_t dct_ridx_i
);

  // Count of assertion failures
  int fail_count = 0;

  // Ack only inside an active bus cycle
  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else begin
      $error("wb_ack_o high without cyc and stb");
      fail_count++;
    end

  // One ack per request
  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("wb_ack_o high for two cycles in a row");
      fail_count++;
    end

  ack_grant_reset: assert property (@(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> (!wb_ack_i && !dat_grant_i && !dct_grant_i))
    else begin
      $error("ack or grant high around reset");
      fail_count++;
    end

  grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(dat_grant_i && dct_grant_i))
    else begin
      $error("DAT and DCT grants high together");
      fail_count++;
    end

  // Controller strobes carry a known index
  hw_idx_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dat_rd_i |-> !$isunknown(dat_idx_i)) and (dct_wr_i |-> !$isunknown(dct_widx_i)) and
    (dct_rd_i |-> !$isunknown(dct_ridx_i)))
    else begin
      $error("controller access with an unknown index");
      fail_count++;
    end

endmodule

bind dxt_top dxt_checker dxt_checker_i (
  .clk_i(clk_i), .rst_ni(rst_ni), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
  .wb_ack_i(wb_ack_o), .dat_grant_i(dat_grant), .dct_grant_i(dct_grant),
  .dat_rd_i(dat_rd_i), .dat_idx_i(dat_idx_i), .dct_wr_i(dct_wr_i),
  .dct_widx_i(dct_widx_i), .dct_rd_i(dct_rd_i), .dct_ridx_i(dct_ridx_i)
);

`default_nettype wire

// ==== design/dxt_top.sv ====
// ##########################################################################
// DXT top: device address and context tables behind a Wishbone slave
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "dxt_config.svh"

module dxt_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Wishbone classic slave
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`DXT_ADR_W-1:0] wb_adr_i,
  input  logic [`DXT_WB_DW-1:0] wb_dat_i,
  output logic [`DXT_WB_DW-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  // Controller DAT read
  input  logic                  dat_rd_i,
  input  dxt_pkg::dat_idx_t     dat_idx_i,
  output dxt_pkg::dat_entry_t   dat_rdata_o,
  // Controller DCT write and read
  input  logic                  dct_wr_i,
  input  dxt_pkg::dct_idx_t     dct_widx_i,
  input  dxt_pkg::dct_entry_t   dct_wdata_i,
  input  logic                  dct_rd_i,
  input  dxt_pkg::dct_idx_t     dct_ridx_i,
  output dxt_pkg::dct_entry_t   dct_rdata_o
);
  import dxt_pkg::*;

  localparam int unsigned IdxW = ($bits(dat_idx_t) > $bits(dct_idx_t)) ?
                                 $bits(dat_idx_t) : $bits(dct_idx_t);

  logic                  req_valid;
  tbl_sel_e              req_tbl;
  logic [IdxW-1:0]       req_idx;
  word_idx_t             req_word;
  logic                  req_we;
  logic [`DXT_WB_DW-1:0] req_wdata;
  logic                  dat_grant;
  logic                  dct_grant;
  logic                  none_grant;
  logic                  dat_mem_req;
  logic                  dat_mem_we;
  dat_idx_t              dat_mem_addr;
  dat_entry_t            dat_mem_wmask;
  dat_entry_t            dat_mem_wdata;
  logic                  dct_mem_req;
  logic                  dct_mem_we;
  dct_idx_t              dct_mem_addr;
  dct_entry_t            dct_mem_wmask;
  dct_entry_t            dct_mem_wdata;

  // Unmapped requests and DCT writes complete without a memory access
  assign none_grant = req_valid &
                      ((req_tbl == TBL_NONE) | ((req_tbl == TBL_DCT) & req_we));

  dxt_wb_decode #(.IdxW(IdxW)) wb_decode_i (
    .clk_i, .rst_ni, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_ack_i(wb_ack_o), .dat_grant_i(dat_grant), .dct_grant_i(dct_grant),
    .req_valid_o(req_valid), .req_tbl_o(req_tbl), .req_idx_o(req_idx),
    .req_word_o(req_word), .req_we_o(req_we), .req_wdata_o(req_wdata)
  );

  dxt_table_port #(.entry_t(dat_entry_t), .Depth(`DXT_DAT_DEPTH)) dat_port_i (
    .clk_i, .rst_ni, .hw_rd_i(dat_rd_i), .hw_wr_i(1'b0), .hw_idx_i(dat_idx_i),
    .hw_wdata_i(dat_entry_t'('0)),
    .sw_valid_i(req_valid & (req_tbl == TBL_DAT)), .sw_idx_i(dat_idx_t'(req_idx)),
    .sw_word_i(req_word), .sw_we_i(req_we), .sw_wdata_i(req_wdata),
    .grant_o(dat_grant), .mem_req_o(dat_mem_req), .mem_we_o(dat_mem_we),
    .mem_addr_o(dat_mem_addr), .mem_wmask_o(dat_mem_wmask), .mem_wdata_o(dat_mem_wdata)
  );

  // Software has read-only access to the DCT
  dxt_table_port #(.entry_t(dct_entry_t), .Depth(`DXT_DCT_DEPTH)) dct_port_i (
    .clk_i, .rst_ni, .hw_rd_i(dct_rd_i), .hw_wr_i(dct_wr_i),
    .hw_idx_i(dct_wr_i ? dct_widx_i : dct_ridx_i), .hw_wdata_i(dct_wdata_i),
    .sw_valid_i(req_valid & (req_tbl == TBL_DCT) & ~req_we),
    .sw_idx_i(dct_idx_t'(req_idx)), .sw_word_i(req_word), .sw_we_i(1'b0),
    .sw_wdata_i(req_wdata), .grant_o(dct_grant), .mem_req_o(dct_mem_req),
    .mem_we_o(dct_mem_we), .mem_addr_o(dct_mem_addr), .mem_wmask_o(dct_mem_wmask),
    .mem_wdata_o(dct_mem_wdata)
  );

  dxt_table_ram #(.entry_t(dat_entry_t), .Depth(`DXT_DAT_DEPTH)) dat_ram_i (
    .clk_i, .rst_ni, .req_i(dat_mem_req), .we_i(dat_mem_we), .addr_i(dat_mem_addr),
    .wmask_i(dat_mem_wmask), .wdata_i(dat_mem_wdata), .rdata_o(dat_rdata_o)
  );

  dxt_table_ram #(.entry_t(dct_entry_t), .Depth(`DXT_DCT_DEPTH)) dct_ram_i (
    .clk_i, .rst_ni, .req_i(dct_mem_req), .we_i(dct_mem_we), .addr_i(dct_mem_addr),
    .wmask_i(dct_mem_wmask), .wdata_i(dct_mem_wdata), .rdata_o(dct_rdata_o)
  );

  // DAT writes return no data, so they ack like an unmapped access
  dxt_wb_result wb_result_i (
    .clk_i, .rst_ni, .dat_grant_i(dat_grant & ~req_we), .dct_grant_i(dct_grant),
    .none_grant_i(none_grant | (dat_grant & req_we)), .req_tbl_i(req_tbl),
    .req_word_i(req_word), .dat_rdata_i(dat_rdata_o), .dct_rdata_i(dct_rdata_o),
    .wb_dat_o, .wb_ack_o
  );

endmodule

`default_nettype wire

// ==== design/dxt_wb_result.sv ====
// ##########################################################################
// DXT result stage, picks the read word and raises the Wishbone ack
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "dxt_config.svh"

module dxt_wb_result (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  dat_grant_i,
  input  logic                  dct_grant_i,
  input  logic                  none_grant_i,
  input  dxt_pkg::tbl_sel_e     req_tbl_i,
  input  dxt_pkg::word_idx_t    req_word_i,
  input  dxt_pkg::dat_entry_t   dat_rdata_i,
  input  dxt_pkg::dct_entry_t   dct_rdata_i,
  output logic [`DXT_WB_DW-1:0] wb_dat_o,
  output logic                  wb_ack_o
);
  import dxt_pkg::*;

  logic                  dat_sel_q;
  logic                  dct_sel_q;
  logic                  none_sel_q;
  logic [`DXT_WB_DW-1:0] rd_word;

  // Grants delayed one cycle to meet the memory read data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dat_sel_q  <= 1'b0;
      dct_sel_q  <= 1'b0;
      none_sel_q <= 1'b0;
    end else begin
      dat_sel_q  <= dat_grant_i;
      dct_sel_q  <= dct_grant_i;
      none_sel_q <= none_grant_i;
    end
  end

  // DAT only has words 0 and 1
  always_comb begin
    case (req_tbl_i)
      TBL_DAT: rd_word = dat_rdata_i[req_word_i[0]*`DXT_WB_DW +: `DXT_WB_DW];
      TBL_DCT: rd_word = dct_rdata_i[req_word_i*`DXT_WB_DW +: `DXT_WB_DW];
      default: rd_word = '0;
    endcase
  end

  // Data bus is zero outside the ack cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      wb_ack_o <= dat_sel_q | dct_sel_q | none_sel_q;
      wb_dat_o <= (dat_sel_q | dct_sel_q) ? rd_word : '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/dxt_table_ram.sv ====
// ##########################################################################
// DXT table memory, synchronous read and bit-masked write
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "dxt_config.svh"

module dxt_table_ram #(
  parameter type         entry_t = logic [63:0],
  parameter int unsigned Depth   = `DXT_DAT_DEPTH
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  entry_t                   wmask_i,
  input  entry_t                   wdata_i,
  output entry_t                   rdata_o
);

  entry_t mem_q [Depth];

  // Read returns the entry as it was before a write in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
      end
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== design/dxt_table_port.sv ====
// ##########################################################################
// DXT table access port, arbitrates controller and software accesses
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "dxt_config.svh"

module dxt_table_port #(
  parameter type         entry_t = logic [63:0],
  parameter int unsigned Depth   = `DXT_DAT_DEPTH
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Controller side
  input  logic                     hw_rd_i,
  input  logic                     hw_wr_i,
  input  logic [$clog2(Depth)-1:0] hw_idx_i,
  input  entry_t                   hw_wdata_i,
  // Software side
  input  logic                     sw_valid_i,
  input  logic [$clog2(Depth)-1:0] sw_idx_i,
  input  dxt_pkg::word_idx_t       sw_word_i,
  input  logic                     sw_we_i,
  input  logic [`DXT_WB_DW-1:0]    sw_wdata_i,
  output logic                     grant_o,
  // Memory side
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output logic [$clog2(Depth)-1:0] mem_addr_o,
  output entry_t                   mem_wmask_o,
  output entry_t                   mem_wdata_o
);

  localparam int unsigned Words = $bits(entry_t) / `DXT_WB_DW;

  logic   hw_act;
  logic   granted_q;
  logic   word_ok;
  entry_t word_mask;
  entry_t word_data;

  assign hw_act = hw_rd_i | hw_wr_i;

  // Software waits out any controller access to this table
  assign grant_o = sw_valid_i & ~hw_act & ~granted_q;

  // Place the bus word at its slot inside the entry
  assign word_ok   = 32'(sw_word_i) < Words;
  assign word_mask = word_ok ?
                     entry_t'({`DXT_WB_DW{1'b1}}) << (sw_word_i * `DXT_WB_DW) : '0;
  assign word_data = entry_t'(sw_wdata_i) << (sw_word_i * `DXT_WB_DW);

  always_comb begin
    if (hw_act) begin
      // Write wins if both controller strobes are raised
      mem_req_o   = 1'b1;
      mem_we_o    = hw_wr_i;
      mem_addr_o  = hw_idx_i;
      mem_wmask_o = '1;
      mem_wdata_o = hw_wdata_i;
    end else begin
      mem_req_o   = grant_o;
      mem_we_o    = grant_o & sw_we_i;
      mem_addr_o  = sw_idx_i;
      mem_wmask_o = word_mask;
      mem_wdata_o = word_data;
    end
  end

  // Held until the decoder drops its valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      granted_q <= 1'b0;
    end else if (grant_o) begin
      granted_q <= 1'b1;
    end else if (!sw_valid_i) begin
      granted_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/dxt_wb_decode.sv ====
// ##########################################################################
// DXT Wishbone request decoder, holds one request until it is acknowledged
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "dxt_config.svh"

module dxt_wb_decode #(
  parameter int unsigned IdxW =
    ($bits(dxt_pkg::dat_idx_t) > $bits(dxt_pkg::dct_idx_t)) ?
    $bits(dxt_pkg::dat_idx_t) : $bits(dxt_pkg::dct_idx_t)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`DXT_ADR_W-1:0] wb_adr_i,
  input  logic [`DXT_WB_DW-1:0] wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  dat_grant_i,
  input  logic                  dct_grant_i,
  output logic                  req_valid_o,
  output dxt_pkg::tbl_sel_e     req_tbl_o,
  output logic [IdxW-1:0]       req_idx_o,
  output dxt_pkg::word_idx_t    req_word_o,
  output logic                  req_we_o,
  output logic [`DXT_WB_DW-1:0] req_wdata_o
);
  import dxt_pkg::*;

  localparam int unsigned DatEnd = `DXT_DAT_BASE + `DXT_DAT_DEPTH * 8;
  localparam int unsigned DctEnd = `DXT_DCT_BASE + `DXT_DCT_DEPTH * 16;

  int unsigned           adr_u;
  logic [`DXT_ADR_W-1:0] dat_off;
  logic [`DXT_ADR_W-1:0] dct_off;
  tbl_sel_e              adr_tbl;
  logic [IdxW-1:0]       adr_idx;
  word_idx_t             adr_word;
  logic                  busy_q;
  logic                  accept;
  logic                  granted;

  assign adr_u   = 32'(wb_adr_i);
  assign dat_off = wb_adr_i - `DXT_DAT_BASE;
  assign dct_off = wb_adr_i - `DXT_DCT_BASE;

  // Eight bytes per DAT entry, sixteen per DCT entry
  always_comb begin
    adr_tbl  = TBL_NONE;
    adr_idx  = '0;
    adr_word = '0;
    if (adr_u >= `DXT_DAT_BASE && adr_u < DatEnd) begin
      adr_tbl  = TBL_DAT;
      adr_idx  = IdxW'(dat_off[3 +: $bits(dat_idx_t)]);
      adr_word = word_idx_t'(dat_off[2]);
    end else if (adr_u >= `DXT_DCT_BASE && adr_u < DctEnd) begin
      adr_tbl  = TBL_DCT;
      adr_idx  = IdxW'(dct_off[4 +: $bits(dct_idx_t)]);
      adr_word = dct_off[3:2];
    end
  end

  assign accept = wb_cyc_i & wb_stb_i & ~busy_q;

  // Unmapped requests and DCT writes never wait on a table
  always_comb begin
    case (req_tbl_o)
      TBL_DAT: granted = dat_grant_i;
      TBL_DCT: granted = dct_grant_i | req_we_o;
      default: granted = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      req_valid_o <= 1'b0;
      req_tbl_o   <= TBL_NONE;
    end else if (accept) begin
      busy_q      <= 1'b1;
      req_valid_o <= 1'b1;
      req_tbl_o   <= adr_tbl;
    end else begin
      if (wb_ack_i) begin
        busy_q <= 1'b0;
      end
      if (granted) begin
        req_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_idx_o   <= adr_idx;
      req_word_o  <= adr_word;
      req_we_o    <= wb_we_i;
      req_wdata_o <= wb_dat_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/dxt_pkg.sv ====
// ##########################################################################
// DXT shared types: table entries, indices and table select
// ##########################################################################

`default_nettype none

`include "dxt_config.svh"

package dxt_pkg;

  localparam int unsigned WordW = `DXT_WB_DW;

  // DAT entry holds two bus words
  typedef logic [2*WordW-1:0] dat_entry_t;

  // DCT entry holds four bus words
  typedef logic [4*WordW-1:0] dct_entry_t;

  // Entry indices
  typedef logic [$clog2(`DXT_DAT_DEPTH)-1:0] dat_idx_t;
  typedef logic [$clog2(`DXT_DCT_DEPTH)-1:0] dct_idx_t;

  // Bus word within an entry
  typedef logic [1:0] word_idx_t;

  // Target of a software request
  typedef enum logic [1:0] {
    TBL_DAT  = 2'd0,
    TBL_DCT  = 2'd1,
    TBL_NONE = 2'd2
  } tbl_sel_e;

endpackage

`default_nettype wire

// ==== design/dxt_config.svh ====
// ##########################################################################
// DXT configuration: table depths, Wishbone address map and bus width
// ##########################################################################

`ifndef DXT_CONFIG_SVH
`define DXT_CONFIG_SVH

// Table depths in entries
`define DXT_DAT_DEPTH 128
`define DXT_DCT_DEPTH 128

// Wishbone byte address and data widths
`define DXT_ADR_W 12
`define DXT_WB_DW 32

// Window bases, DAT spans depth*8 bytes and DCT spans depth*16 bytes
`define DXT_DAT_BASE 12'h000
`define DXT_DCT_BASE 12'h800

`endif
